// File: common/decode_pkg.sv
`default_nettype none

package decode_pkg;

    localparam int window_bytes = 15;
    localparam int max_prefixes = 4;

    // modrm field codes
    localparam logic [1:0] mod_mem = 2'b00;
    localparam logic [1:0] mod_reg = 2'b11;
    localparam logic [2:0] rm_sib = 3'b100;
    localparam logic [2:0] rm_disp32 = 3'b101;
    localparam logic [2:0] rm16_disp16 = 3'b110;

    typedef logic [0:window_bytes-1][7:0] insn_window_t;

    typedef enum logic [1:0] {
        disp_none,
        disp_8,
        disp_16,
        disp_32
    } disp_size_e;

    typedef enum logic [2:0] {
        imm_none,
        imm_8,
        imm_16,
        imm_32,
        imm_48
    } imm_size_e;

    typedef enum logic [7:0] {
        pfx_es = 8'h26,
        pfx_cs = 8'h2E,
        pfx_ss = 8'h36,
        pfx_ds = 8'h3E,
        pfx_fs = 8'h64,
        pfx_gs = 8'h65,
        pfx_opsize = 8'h66,
        pfx_addrsize = 8'h67,
        pfx_lock = 8'hF0,
        pfx_repne = 8'hF2,
        pfx_rep = 8'hF3
    } prefix_e;

    ////////////////////////////////
    // one byte opcode map
    ////////////////////////////////
    typedef enum logic [7:0] {
        op_add_al_ib = 8'h04,
        op_add_eax_iz = 8'h05,
        op_two_byte = 8'h0F,
        op_push_iz = 8'h68,
        op_push_ib = 8'h6A,
        op_grp1_eb_ib = 8'h80,
        op_grp1_ev_iz = 8'h81,
        op_grp1_ev_ib = 8'h83,
        op_mov_ev_gv = 8'h89,
        op_mov_gv_ev = 8'h8B,
        op_mov_r_iz = 8'hB8,
        op_ret_iw = 8'hC2,
        op_mov_eb_ib = 8'hC6,
        op_mov_ev_iz = 8'hC7,
        op_int_ib = 8'hCD,
        op_jmp_far = 8'hEA
    } opcode_e;

    // second byte after 0F
    typedef enum logic [7:0] {
        op0f_jcc = 8'h80,
        op0f_imul_gv_ev = 8'hAF,
        op0f_bt_ev_ib = 8'hBA
    } opcode_0f_e;

    typedef struct packed {
        logic [2:0] count;
        logic op32;
        logic addr32;
    } prefix_info_t;

    typedef struct packed {
        logic double;
        logic has_modrm;
        imm_size_e imm;
    } op_class_t;

    typedef struct packed {
        logic [1:0] modrm_len;
        disp_size_e disp;
    } modrm_info_t;

    typedef struct packed {
        logic [31:0] displacement;
        logic [47:0] immediate;
        logic [3:0] length;
    } field_out_t;

endpackage

`default_nettype wire

// File: source/decode_mode_reg.sv
`timescale 1ns/10ps
`default_nettype none

module decode_mode_reg (
    input wire clk,
    input wire rst_n,
    input wire cfg_write,
    input wire cfg_d32,
    output logic d32
);

    // code segment D bit resets to 32-bit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            d32 <= 1'b1;
        end else if (cfg_write) begin
            d32 <= cfg_d32;
        end
    end

endmodule

`default_nettype wire

// File: decode/prefix_scan.sv
`timescale 1ns/10ps
`default_nettype none

module prefix_scan
    import decode_pkg::*;
(
    input wire insn_window_t in_bytes,
    input wire d32,
    output prefix_info_t prefix_info
);

    logic scanning;
    logic saw_opsize;
    logic saw_addrsize;
    logic [2:0] count;

    function automatic logic is_prefix(input logic [7:0] b);
        case (b)
            pfx_es, pfx_cs, pfx_ss, pfx_ds, pfx_fs, pfx_gs: begin
                is_prefix = 1'b1;
            end
            pfx_opsize, pfx_addrsize: begin
                is_prefix = 1'b1;
            end
            pfx_lock, pfx_repne, pfx_rep: begin
                is_prefix = 1'b1;
            end
            default: begin
                is_prefix = 1'b0;
            end
        endcase
    endfunction

    ////////////////////////////////
    // leading prefix scan
    ////////////////////////////////
    // stops at the first non prefix; a fifth prefix byte is the opcode
    always_comb begin
        scanning = 1'b1;
        saw_opsize = 1'b0;
        saw_addrsize = 1'b0;
        count = 3'd0;
        for (int i = 0; i < max_prefixes; i++) begin
            if (scanning && is_prefix(in_bytes[i])) begin
                count = count + 3'd1;
                if (in_bytes[i] == pfx_opsize) begin
                    saw_opsize = 1'b1;
                end
                if (in_bytes[i] == pfx_addrsize) begin
                    saw_addrsize = 1'b1;
                end
            end else begin
                scanning = 1'b0;
            end
        end
    end

    // 66 and 67 flip the default size
    always_comb begin
        prefix_info.count = count;
        prefix_info.op32 = d32 ^ saw_opsize;
        prefix_info.addr32 = d32 ^ saw_addrsize;
    end

endmodule

`default_nettype wire

// File: decode/opcode_class.sv
`timescale 1ns/10ps
`default_nettype none

module opcode_class
    import decode_pkg::*;
(
    input wire insn_window_t in_bytes,
    input wire prefix_info_t prefix_info,
    output op_class_t op_class
);

    logic [7:0] first;
    logic [7:0] second;
    imm_size_e imm_z;
    imm_size_e imm_far;

    assign first = in_bytes[prefix_info.count];
    assign second = in_bytes[prefix_info.count + 3'd1];

    // z sized immediate follows the operand size
    always_comb begin
        if (prefix_info.op32) begin
            imm_z = imm_32;
            imm_far = imm_48;
        end else begin
            imm_z = imm_16;
            imm_far = imm_32;
        end
    end

    ////////////////////////////////
    // opcode table
    ////////////////////////////////
    always_comb begin
        op_class = '0;
        if (first == op_two_byte) begin
            op_class.double = 1'b1;
            if ((second & 8'hF0) == op0f_jcc) begin
                // jcc rel16/32
                op_class.imm = imm_z;
            end else begin
                case (second)
                    op0f_imul_gv_ev: begin
                        op_class.has_modrm = 1'b1;
                    end
                    op0f_bt_ev_ib: begin
                        op_class.has_modrm = 1'b1;
                        op_class.imm = imm_8;
                    end
                    default: begin
                        op_class.has_modrm = 1'b0;
                    end
                endcase
            end
        end else if ((first & 8'hF8) == op_mov_r_iz) begin
            // mov reg, imm for all eight registers
            op_class.imm = imm_z;
        end else begin
            case (first)
                op_add_al_ib, op_push_ib, op_int_ib: begin
                    op_class.imm = imm_8;
                end
                op_add_eax_iz, op_push_iz: begin
                    op_class.imm = imm_z;
                end
                op_ret_iw: begin
                    op_class.imm = imm_16;
                end
                op_jmp_far: begin
                    op_class.imm = imm_far;
                end
                op_grp1_eb_ib, op_grp1_ev_ib, op_mov_eb_ib: begin
                    op_class.has_modrm = 1'b1;
                    op_class.imm = imm_8;
                end
                op_grp1_ev_iz, op_mov_ev_iz: begin
                    op_class.has_modrm = 1'b1;
                    op_class.imm = imm_z;
                end
                op_mov_ev_gv, op_mov_gv_ev: begin
                    op_class.has_modrm = 1'b1;
                end
                default: begin
                    op_class.imm = imm_none;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: decode/modrm_decode.sv
`timescale 1ns/10ps
`default_nettype none

module modrm_decode
    import decode_pkg::*;
(
    input wire insn_window_t in_bytes,
    input wire prefix_info_t prefix_info,
    input wire op_class_t op_class,
    output modrm_info_t modrm_info
);

    logic [3:0] modrm_pos;
    logic [7:0] modrm;
    logic [7:0] sib;
    logic [1:0] mod;
    logic [2:0] rm;

    // modrm sits right after the opcode bytes
    assign modrm_pos = 4'(prefix_info.count) + 4'(op_class.double) + 4'd1;
    assign modrm = in_bytes[modrm_pos];
    assign sib = in_bytes[modrm_pos + 4'd1];
    assign mod = modrm[7:6];
    assign rm = modrm[2:0];

    always_comb begin
        modrm_info = '0;
        if (op_class.has_modrm) begin
            modrm_info.modrm_len = 2'd1;
            if (prefix_info.addr32) begin
                // sib only with a memory operand
                if (mod != mod_reg && rm == rm_sib) begin
                    modrm_info.modrm_len = 2'd2;
                end
                case (mod)
                    mod_mem: begin
                        if (rm == rm_disp32 || (rm == rm_sib && sib[2:0] == rm_disp32)) begin
                            modrm_info.disp = disp_32;
                        end
                    end
                    2'b01: modrm_info.disp = disp_8;
                    2'b10: modrm_info.disp = disp_32;
                    default: modrm_info.disp = disp_none;
                endcase
            end else begin
                // 16-bit forms have no sib
                case (mod)
                    mod_mem: begin
                        if (rm == rm16_disp16) begin
                            modrm_info.disp = disp_16;
                        end
                    end
                    2'b01: modrm_info.disp = disp_8;
                    2'b10: modrm_info.disp = disp_16;
                    default: modrm_info.disp = disp_none;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: decode/disp_imm_select.sv
`timescale 1ns/10ps
`default_nettype none

module disp_imm_select
    import decode_pkg::*;
(
    input wire clk,
    input wire rst_n,
    input wire in_valid,
    input wire insn_window_t in_bytes,
    input wire prefix_info_t prefix_info,
    input wire op_class_t op_class,
    input wire modrm_info_t modrm_info,
    output logic out_valid,
    output field_out_t out_fields
);

    logic [4:0] disp_pos;
    logic [4:0] imm_pos;
    logic [4:0] total_len;
    logic [2:0] disp_len;
    logic [2:0] imm_len;
    logic [31:0] disp_raw;
    logic [47:0] imm_raw;
    field_out_t next_fields;

    // past the window reads as zero
    function automatic logic [7:0] window_byte(input insn_window_t win, input logic [4:0] pos);
        if (pos < 5'(window_bytes)) begin
            window_byte = win[pos];
        end else begin
            window_byte = 8'h00;
        end
    endfunction

    always_comb begin
        case (modrm_info.disp)
            disp_8: disp_len = 3'd1;
            disp_16: disp_len = 3'd2;
            disp_32: disp_len = 3'd4;
            default: disp_len = 3'd0;
        endcase
        case (op_class.imm)
            imm_8: imm_len = 3'd1;
            imm_16: imm_len = 3'd2;
            imm_32: imm_len = 3'd4;
            imm_48: imm_len = 3'd6;
            default: imm_len = 3'd0;
        endcase
    end

    ////////////////////////////////
    // field offsets
    ////////////////////////////////
    assign disp_pos = 5'(prefix_info.count) + 5'(op_class.double) + 5'd1
                    + 5'(modrm_info.modrm_len);
    assign imm_pos = disp_pos + 5'(disp_len);
    assign total_len = imm_pos + 5'(imm_len);

    // little-endian gather
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            disp_raw[8*i +: 8] = window_byte(in_bytes, disp_pos + 5'(i));
        end
        for (int i = 0; i < 6; i++) begin
            imm_raw[8*i +: 8] = window_byte(in_bytes, imm_pos + 5'(i));
        end
    end

    ////////////////////////////////
    // sign extension
    ////////////////////////////////
    always_comb begin
        case (modrm_info.disp)
            disp_8: next_fields.displacement = {{24{disp_raw[7]}}, disp_raw[7:0]};
            disp_16: next_fields.displacement = {{16{disp_raw[15]}}, disp_raw[15:0]};
            disp_32: next_fields.displacement = disp_raw;
            default: next_fields.displacement = 32'd0;
        endcase
        case (op_class.imm)
            imm_8: next_fields.immediate = {{40{imm_raw[7]}}, imm_raw[7:0]};
            imm_16: next_fields.immediate = {{32{imm_raw[15]}}, imm_raw[15:0]};
            imm_32: next_fields.immediate = {{16{imm_raw[31]}}, imm_raw[31:0]};
            imm_48: next_fields.immediate = imm_raw;
            default: next_fields.immediate = 48'd0;
        endcase
        next_fields.length = total_len[3:0];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_fields <= '0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                out_fields <= next_fields;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/x86_field_decode.sv
`timescale 1ns/10ps
`default_nettype none

module x86_field_decode
    import decode_pkg::*;
(
    input wire clk,
    input wire rst_n,
    input wire cfg_write,
    input wire cfg_d32,
    input wire in_valid,
    input wire insn_window_t in_bytes,
    output logic out_valid,
    output field_out_t out_fields
);

    logic d32;
    prefix_info_t prefix_info;
    op_class_t op_class;
    modrm_info_t modrm_info;

    decode_mode_reg i_decode_mode_reg (
        .clk(clk),
        .rst_n(rst_n),
        .cfg_write(cfg_write),
        .cfg_d32(cfg_d32),
        .d32(d32)
    );

    ////////////////////////////////
    // combinational field decode
    ////////////////////////////////
    prefix_scan i_prefix_scan (
        .in_bytes(in_bytes),
        .d32(d32),
        .prefix_info(prefix_info)
    );

    opcode_class i_opcode_class (
        .in_bytes(in_bytes),
        .prefix_info(prefix_info),
        .op_class(op_class)
    );

    modrm_decode i_modrm_decode (
        .in_bytes(in_bytes),
        .prefix_info(prefix_info),
        .op_class(op_class),
        .modrm_info(modrm_info)
    );

    // registered output stage
    disp_imm_select i_disp_imm_select (
        .clk(clk),
        .rst_n(rst_n),
        .in_valid(in_valid),
        .in_bytes(in_bytes),
        .prefix_info(prefix_info),
        .op_class(op_class),
        .modrm_info(modrm_info),
        .out_valid(out_valid),
        .out_fields(out_fields)
    );

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset held low for two rising edges
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: sim/x86_field_decode_tb.sv
`timescale 1ns/10ps
`default_nettype none

module x86_field_decode_tb
    import decode_pkg::*;
();

    localparam int timeout_cycles = 400;

    logic clk;
    logic rst_n;
    logic cfg_write;
    logic cfg_d32;
    logic in_valid;
    insn_window_t in_bytes;
    logic out_valid;
    field_out_t out_fields;

    int errors = 0;
    int checks = 0;
    int cycles = 0;
    logic mode_d32 = 1'b1;
    logic [31:0] lcg_state = 32'h9536;

    tb_clock_gen i_tb_clock_gen (
        .clk(clk),
        .rst_n(rst_n)
    );

    x86_field_decode i_x86_field_decode (
        .clk(clk),
        .rst_n(rst_n),
        .cfg_write(cfg_write),
        .cfg_d32(cfg_d32),
        .in_valid(in_valid),
        .in_bytes(in_bytes),
        .out_valid(out_valid),
        .out_fields(out_fields)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("run stopped after %0d cycles before the tests finished", cycles);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [7:0] rand_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];
    endfunction

    // instruction bytes in memory order then filler
    function automatic insn_window_t build_window(input logic [119:0] code, input int len);
        insn_window_t win;
        for (int i = 0; i < window_bytes; i++) begin
            if (i < len) begin
                win[i] = code[8*(len-1-i) +: 8];
            end else begin
                win[i] = rand_byte();
            end
        end
        return win;
    endfunction

    ////////////////////////////////
    // reference model
    ////////////////////////////////
    function automatic logic legacy_prefix(input logic [7:0] b);
        case (b)
            8'h66, 8'h67, 8'hF0, 8'hF2, 8'hF3: return 1'b1;
            8'h26, 8'h2E, 8'h36, 8'h3E, 8'h64, 8'h65: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [63:0] gather(input insn_window_t win, input int pos,
                                           input int nbytes);
        logic [63:0] raw;
        raw = '0;
        for (int i = 0; i < nbytes; i++) begin
            if (pos + i < window_bytes) begin
                raw[8*i +: 8] = win[pos + i];
            end
        end
        return raw;
    endfunction

    function automatic logic [63:0] sign_extend(input logic [63:0] raw, input int nbytes);
        logic [63:0] v;
        v = raw;
        if (nbytes > 0) begin
            for (int b = 8 * nbytes; b < 64; b++) begin
                v[b] = raw[8*nbytes-1];
            end
        end
        return v;
    endfunction

    function automatic field_out_t ref_decode(input insn_window_t win, input logic d32);
        int npfx;
        int pos;
        int z;
        int imm_n;
        int disp_n;
        int modrm_n;
        logic op32;
        logic a32;
        logic two;
        logic has_modrm;
        logic [7:0] op;
        logic [7:0] modrm;
        logic [63:0] wide;
        field_out_t f;
        npfx = 0;
        op32 = d32;
        a32 = d32;
        while (npfx < 4 && legacy_prefix(win[npfx])) begin
            if (win[npfx] == 8'h66) op32 = !d32;
            if (win[npfx] == 8'h67) a32 = !d32;
            npfx++;
        end
        op = win[npfx];
        two = (op == 8'h0F);
        z = op32 ? 4 : 2;
        imm_n = 0;
        has_modrm = 1'b0;
        if (two) begin
            if (win[npfx+1][7:4] == 4'h8) begin
                imm_n = z;
            end else if (win[npfx+1] == 8'hAF) begin
                has_modrm = 1'b1;
            end else if (win[npfx+1] == 8'hBA) begin
                has_modrm = 1'b1;
                imm_n = 1;
            end
        end else begin
            case (op)
                8'h04, 8'h6A, 8'hCD: imm_n = 1;
                8'h05, 8'h68, 8'hB8, 8'hB9, 8'hBA, 8'hBB, 8'hBC, 8'hBD, 8'hBE, 8'hBF: imm_n = z;
                8'hC2: imm_n = 2;
                8'hEA: imm_n = op32 ? 6 : 4;
                8'h80, 8'h83, 8'hC6: begin
                    has_modrm = 1'b1;
                    imm_n = 1;
                end
                8'h81, 8'hC7: begin
                    has_modrm = 1'b1;
                    imm_n = z;
                end
                8'h89, 8'h8B: has_modrm = 1'b1;
                default: imm_n = 0;
            endcase
        end
        pos = npfx + (two ? 2 : 1);
        modrm_n = 0;
        disp_n = 0;
        if (has_modrm) begin
            modrm = win[pos];
            modrm_n = 1;
            if (a32) begin
                if (modrm[7:6] != 2'b11 && modrm[2:0] == 3'd4) modrm_n = 2;
                if (modrm[7:6] == 2'b00 && (modrm[2:0] == 3'd5
                        || (modrm[2:0] == 3'd4 && win[pos+1][2:0] == 3'd5))) disp_n = 4;
                if (modrm[7:6] == 2'b01) disp_n = 1;
                if (modrm[7:6] == 2'b10) disp_n = 4;
            end else begin
                if (modrm[7:6] == 2'b00 && modrm[2:0] == 3'd6) disp_n = 2;
                if (modrm[7:6] == 2'b01) disp_n = 1;
                if (modrm[7:6] == 2'b10) disp_n = 2;
            end
        end
        pos = pos + modrm_n;
        wide = sign_extend(gather(win, pos, disp_n), disp_n);
        f.displacement = wide[31:0];
        wide = sign_extend(gather(win, pos + disp_n, imm_n), imm_n);
        f.immediate = wide[47:0];
        f.length = 4'(pos + disp_n + imm_n);
        return f;
    endfunction

    ////////////////////////////////
    // drive and check
    ////////////////////////////////
    task automatic check_fields(input field_out_t exp, input string name);
        checks++;
        if (out_valid !== 1'b1) begin
            errors++;
            $display("** Error at %0t: %s out_valid is %b, expected 1", $time, name, out_valid);
        end
        if (out_fields.displacement !== exp.displacement) begin
            errors++;
            $display("** Error at %0t: %s displacement %h, expected %h", $time, name,
                     out_fields.displacement, exp.displacement);
        end
        if (out_fields.immediate !== exp.immediate) begin
            errors++;
            $display("** Error at %0t: %s immediate %h, expected %h", $time, name,
                     out_fields.immediate, exp.immediate);
        end
        if (out_fields.length !== exp.length) begin
            errors++;
            $display("** Error at %0t: %s length %0d, expected %0d", $time, name,
                     out_fields.length, exp.length);
        end
    endtask

    task automatic decode_one(input logic [119:0] code, input int len, input string name);
        insn_window_t win;
        field_out_t exp;
        win = build_window(code, len);
        exp = ref_decode(win, mode_d32);
        if (exp.length != len) begin
            errors++;
            $display("%s: reference length %0d does not match the %0d byte instruction",
                     name, exp.length, len);
        end
        @(posedge clk);
        in_bytes <= win;
        in_valid <= 1'b1;
        @(posedge clk);
        in_valid <= 1'b0;
        @(negedge clk);
        check_fields(exp, name);
    endtask

    task automatic expect_idle(input string name);
        checks++;
        if (out_valid !== 1'b0) begin
            errors++;
            $display("** Error at %0t: %s out_valid is %b, expected 0", $time, name, out_valid);
        end
    endtask

    task automatic write_mode(input logic d32);
        @(posedge clk);
        cfg_write <= 1'b1;
        cfg_d32 <= d32;
        @(posedge clk);
        cfg_write <= 1'b0;
        mode_d32 = d32;
    endtask

    ////////////////////////////////
    // directed tests
    ////////////////////////////////
    task automatic reset_idle();
        @(negedge clk);
        expect_idle("after reset");
        checks++;
        if (out_fields !== '0) begin
            errors++;
            $display("** Error at %0t: out_fields %h after reset, expected 0", $time, out_fields);
        end
        repeat (3) begin
            @(negedge clk);
            expect_idle("idle");
        end
    endtask

    task automatic immediates();
        decode_one(120'h04F0, 2, "add al negative imm8");
        decode_one(120'h0578563492, 5, "add eax negative imm32");
        decode_one(120'h6801020304, 5, "push imm32");
        decode_one(120'hC21080, 3, "ret imm16");
        decode_one(120'hEA443322110800, 7, "jmp far ptr16:32");
    endtask

    task automatic modrm_disp();
        decode_one(120'h8B0578563412, 6, "mov disp32 absolute");
        decode_one(120'h8945F8, 3, "mov negative disp8");
        decode_one(120'hC7042544332211_01000080, 11, "mov sib base 101 imm32");
    endtask

    task automatic prefixes();
        decode_one(120'h66053412, 4, "66 add imm16");
        decode_one(120'h6668FEFF, 4, "66 push negative imm16");
        decode_one(120'h678B060090, 5, "67 mov disp16");
        decode_one(120'h2E3E266465, 5, "four prefixes and a fifth");
        decode_one(120'hF0660FBA601005, 7, "prefixed 0f ba");
        decode_one(120'h660F840080, 5, "66 jcc rel16");
    endtask

    task automatic mode_register();
        write_mode(1'b0);
        decode_one(120'h053412, 3, "16-bit mode add imm16");
        decode_one(120'h8B063412, 4, "16-bit mode mov disp16");
        decode_one(120'h660578563412, 6, "16-bit mode 66 add imm32");
        decode_one(120'h678B0578563412, 7, "16-bit mode 67 mov disp32");
        write_mode(1'b1);
        decode_one(120'h057856341A, 5, "32-bit mode restored");
    endtask

    task automatic back_to_back();
        logic [119:0] codes [5];
        int lens [5];
        insn_window_t wins [5];
        field_out_t exps [5];
        codes[0] = 120'h047F;
        lens[0] = 2;
        codes[1] = 120'h8945F8;
        lens[1] = 3;
        codes[2] = 120'h6800000080;
        lens[2] = 5;
        codes[3] = 120'h0FAFC1;
        lens[3] = 3;
        codes[4] = 120'hC6442408FF;
        lens[4] = 5;
        for (int i = 0; i < 5; i++) begin
            wins[i] = build_window(codes[i], lens[i]);
            exps[i] = ref_decode(wins[i], mode_d32);
        end
        // result i shows up on the edge that takes window i+1
        for (int i = 0; i <= 5; i++) begin
            @(posedge clk);
            if (i < 5) begin
                in_bytes <= wins[i];
                in_valid <= 1'b1;
            end else begin
                in_valid <= 1'b0;
            end
            @(negedge clk);
            if (i > 0) begin
                check_fields(exps[i-1], $sformatf("back to back window %0d", i - 1));
            end
        end
        @(negedge clk);
        expect_idle("after back to back");
    endtask

    initial begin
        cfg_write = 1'b0;
        cfg_d32 = 1'b1;
        in_valid = 1'b0;
        in_bytes = '0;
        wait (rst_n === 1'b1);
        reset_idle();
        immediates();
        modrm_disp();
        prefixes();
        mode_register();
        back_to_back();
        repeat (2) @(posedge clk);
        $display("errors: %0d in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
common/decode_pkg.sv
source/decode_mode_reg.sv
decode/prefix_scan.sv
decode/opcode_class.sv
decode/modrm_decode.sv
decode/disp_imm_select.sv
source/x86_field_decode.sv
sim/tb_clock_gen.sv
sim/x86_field_decode_tb.sv
